// ==== verilog/cu_pkg.sv ====
// widths, micro-state numbering, next-address and status enums, control-word bit map
package cu_pkg;

	// --------------------
	// widths and data types
	// --------------------
	localparam int state_w = 7;                 // micro-state width
	localparam int instr_w = 32;                // instruction register
	localparam int flags_w = 4;                 // nzcv only
	localparam int alu_op_w = 4;                // dp opcode, instr[24:21]
	localparam int ctrl_w = 7;                  // registered control word

	typedef logic [state_w-1:0] state_t;        // micro-state number
	typedef logic [instr_w-1:0] instr_t;        // ir value
	typedef logic [flags_w-1:0] flags_t;        // {n, z, c, v}
	typedef logic [alu_op_w-1:0] alu_op_t;      // and .. mvn
	typedef logic [ctrl_w-1:0] ctrl_t;          // see bit map below

	// --------------------
	// next-address codes
	// --------------------
	// the conditional codes test the selected status after inversion
	typedef enum logic [2:0] {
		ns_dispatch           = 3'b000,         // decoder output
		ns_zero               = 3'b001,         // back to state 0
		ns_jump               = 3'b010,         // microword jump address
		ns_incr               = 3'b011,         // state + 1
		ns_jump_else_dispatch = 3'b100,         // sts ? jump : dispatch
		ns_jump_else_incr     = 3'b101,         // sts ? jump : state + 1
		ns_dispatch_else_incr = 3'b110,         // sts ? dispatch : state + 1
		ns_zero_b             = 3'b111          // second encoding of zero
	} next_sel_e;

	// status sources for the conditional codes
	typedef enum logic [1:0] {
		cs_mfc       = 2'b00,                   // memory function complete
		cs_cond_pass = 2'b01,                   // condition evaluator
		cs_none      = 2'b10                    // constant zero
	} cond_sel_e;

	// --------------------
	// micro-state numbering
	// --------------------
	localparam state_t st_reset = 7'd0;         // entered from reset only
	localparam state_t st_addr = 7'd1;          // fetch start, refetch target
	localparam state_t st_pc_inc = 7'd2;        // pc update
	localparam state_t st_mem_wait = 7'd3;      // wait for mfc
	localparam state_t st_decode = 7'd4;        // ir load, cond check, dispatch
	localparam state_t st_dp_first = 7'd5;      // and immediate
	localparam state_t st_last = 7'd36;         // mvn register

	// --------------------
	// control-word bit map
	// --------------------
	localparam int ctrl_mfa = 0;                // memory function active
	localparam int ctrl_ir_load = 1;            // latch instruction
	localparam int ctrl_pc_write = 2;           // pc <= pc + 4
	localparam int ctrl_imm_sel = 3;            // alu operand b from immediate
	localparam int ctrl_rf_write = 4;           // write back rd
	localparam int ctrl_flags_write = 5;        // nzcv update, compares only
	localparam int ctrl_alu_en = 6;             // alu opcode valid this word

	// --------------------
	// dp encodings
	// --------------------
	localparam logic [2:0] dp_form_imm = 3'b001;    // instr[27:25], 32-bit immediate
	localparam logic [2:0] dp_form_reg = 3'b000;    // instr[27:25], immediate shift

endpackage

// ==== verilog/microword_if.sv ====
// next-address fields of the microword, rom to sequencer
`timescale 1ns/1ps

interface microword_if;
	import cu_pkg::*;

	next_sel_e next_sel;    // next-address code
	logic inv;              // invert selected status
	cond_sel_e cond_sel;    // status source
	state_t jump;           // jump address

	// rom side, table lookup
	modport rom (
		output next_sel,
		output inv,
		output cond_sel,
		output jump
	);

	// sequencer side
	modport seq (
		input next_sel,
		input inv,
		input cond_sel,
		input jump
	);

endinterface

// ==== verilog/cond_eval.sv ====
// condition-code evaluator over nzcv
`timescale 1ns/1ps

module cond_eval (
	input cu_pkg::instr_t instr,
	input cu_pkg::flags_t flags,
	output logic cond_pass
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = flags[3];    // msb
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (instr[31:28])
			4'b0000: cond_pass = z;                     // eq
			4'b0001: cond_pass = !z;                    // ne
			4'b0010: cond_pass = c;                     // cs
			4'b0011: cond_pass = !c;                    // cc
			4'b0100: cond_pass = n;                     // mi
			4'b0101: cond_pass = !n;                    // pl
			4'b0110: cond_pass = v;                     // vs
			4'b0111: cond_pass = !v;                    // vc
			4'b1000: cond_pass = c && !z;               // hi
			4'b1001: cond_pass = !c || z;               // ls
			4'b1010: cond_pass = (n == v);              // ge
			4'b1011: cond_pass = (n != v);              // lt
			4'b1100: cond_pass = !z && (n == v);        // gt
			4'b1101: cond_pass = z || (n != v);         // le
			4'b1110: cond_pass = 1'b1;                  // al
			default: cond_pass = 1'b0;                  // nv, never
		endcase
	end

endmodule

// ==== verilog/instr_decoder.sv ====
// dispatch decoder, instruction to data-processing micro-state
`timescale 1ns/1ps

module instr_decoder (
	input cu_pkg::instr_t instr,
	output cu_pkg::state_t dispatch
);
	import cu_pkg::*;

	logic [2:0] form;       // instr[27:25]
	alu_op_t op;            // instr[24:21]
	logic misc;             // misc space, status moves etc
	logic is_imm;
	logic is_reg;
	state_t dp_base;        // st_dp_first + 2 * op

	assign form = instr[27:25];
	assign op = instr[24:21];

	// bits 24:23 = 10 with s clear are tst..cmn without flags, not dp
	assign misc = (instr[24:23] == 2'b10) && !instr[20];

	assign is_imm = (form == dp_form_imm) && !misc;
	// register shift (bit 4 set) is not supported here
	assign is_reg = (form == dp_form_reg) && !instr[4] && !misc;

	assign dp_base = st_dp_first + state_t'({op, 1'b0});

	always_comb begin
		if (is_imm) begin
			dispatch = dp_base;                     // odd states
		end else if (is_reg) begin
			dispatch = dp_base + state_t'(1);       // even states
		end else begin
			// ld/st, branch, multiples, misc, undefined
			dispatch = st_addr;                     // refetch
		end
	end

endmodule

// ==== verilog/micro_rom.sv ====
// microcode table, next-address fields and registered control word
`timescale 1ns/1ps

module micro_rom #(
	parameter cu_pkg::state_t last_state = cu_pkg::st_last
) (
	input logic clk,
	input logic arst_n,
	input cu_pkg::state_t state,
	microword_if.rom mw,
	output cu_pkg::ctrl_t ctrl
);
	import cu_pkg::*;

	ctrl_t ctrl_next;       // word of the current state
	state_t dp_offset;      // state - st_dp_first
	alu_op_t dp_op;         // opcode behind a dp state
	logic is_dp;

	assign dp_offset = state - st_dp_first;
	assign dp_op = dp_offset[4:1];
	assign is_dp = (state >= st_dp_first) && (state <= last_state);

	// --------------------
	// table lookup
	// --------------------
	always_comb begin
		// st_addr entry, also used by st_reset and unused addresses
		mw.next_sel = ns_incr;
		mw.inv = 1'b0;
		mw.cond_sel = cs_none;
		mw.jump = st_addr;
		ctrl_next = '0;

		if (is_dp) begin
			// one cycle per opcode, then refetch
			mw.next_sel = ns_jump;
			mw.jump = st_addr;
			ctrl_next[ctrl_alu_en] = 1'b1;
			ctrl_next[ctrl_imm_sel] = state[0];                 // odd = immediate
			ctrl_next[ctrl_rf_write] = (dp_op[3:2] != 2'b10);   // tst teq cmp cmn
			ctrl_next[ctrl_flags_write] = (dp_op[3:2] == 2'b10);
		end else begin
			case (state)
				st_pc_inc: begin
					ctrl_next[ctrl_pc_write] = 1'b1;
				end
				st_mem_wait: begin
					// loop on ~mfc
					mw.next_sel = ns_jump_else_incr;
					mw.cond_sel = cs_mfc;
					mw.inv = 1'b1;
					mw.jump = st_mem_wait;
					ctrl_next[ctrl_mfa] = 1'b1;
				end
				st_decode: begin
					// failed condition goes back to fetch
					mw.next_sel = ns_jump_else_dispatch;
					mw.cond_sel = cs_cond_pass;
					mw.inv = 1'b1;
					mw.jump = st_addr;
					ctrl_next[ctrl_ir_load] = 1'b1;
				end
				default: begin
					// st_reset, st_addr, unused: plain increment
					ctrl_next = '0;
				end
			endcase
		end
	end

	// --------------------
	// control-word register
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;         // all controls idle
		end else begin
			ctrl <= ctrl_next;  // one cycle behind state
		end
	end

	// a memory access never overlaps a register write
	a_no_mfa_with_rf_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(ctrl[ctrl_mfa] && ctrl[ctrl_rf_write]));

endmodule

// ==== verilog/microsequencer.sv ====
// micro-state register, incrementer, status mux and next-address select
`timescale 1ns/1ps

module microsequencer #(
	parameter cu_pkg::state_t last_state = cu_pkg::st_last
) (
	input logic clk,
	input logic arst_n,
	microword_if.seq mw,
	input cu_pkg::state_t dispatch,
	input logic cond_pass,
	input logic mfc,
	output cu_pkg::state_t state
);
	import cu_pkg::*;

	logic sts_raw;          // selected status
	logic sts;              // after inversion
	state_t state_inc;      // incrementer
	state_t state_next;

	assign state_inc = state + state_t'(1);

	// --------------------
	// status source
	// --------------------
	always_comb begin
		case (mw.cond_sel)
			cs_mfc: sts_raw = mfc;
			cs_cond_pass: sts_raw = cond_pass;
			default: sts_raw = 1'b0;        // cs_none, unused code
		endcase
	end

	assign sts = sts_raw ^ mw.inv;

	// --------------------
	// next-address select
	// --------------------
	always_comb begin
		case (mw.next_sel)
			ns_dispatch: state_next = dispatch;
			ns_zero: state_next = st_reset;
			ns_jump: state_next = mw.jump;
			ns_incr: state_next = state_inc;
			ns_jump_else_dispatch: state_next = sts ? mw.jump : dispatch;
			ns_jump_else_incr: state_next = sts ? mw.jump : state_inc;
			ns_dispatch_else_incr: state_next = sts ? dispatch : state_inc;
			default: state_next = st_reset;         // ns_zero_b
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_reset;
		end else begin
			state <= state_next;
		end
	end

	// rom table and decoder together keep the state inside the microprogram
	a_state_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		state <= last_state);

endmodule

// ==== verilog/control_unit.sv ====
// control unit top, sequencer, rom, decoder, condition check, control outputs
`timescale 1ns/1ps

module control_unit #(
	parameter cu_pkg::state_t last_state = cu_pkg::st_last
) (
	input logic clk,
	input logic arst_n,
	input cu_pkg::instr_t instr,
	input cu_pkg::flags_t flags,
	input logic mfc,
	output logic mfa,
	output logic ir_load,
	output logic pc_write,
	output cu_pkg::alu_op_t alu_op,
	output logic imm_sel,
	output logic rf_write,
	output logic flags_write
);
	import cu_pkg::*;

	state_t state;          // current micro-state
	state_t dispatch;       // decoder target
	ctrl_t ctrl;            // registered control word
	logic cond_pass;
	alu_op_t alu_op_q;      // opcode sampled with ctrl

	microword_if mw ();

	microsequencer #(.last_state(last_state)) microsequencer_inst (
		.clk(clk),
		.arst_n(arst_n),
		.mw(mw.seq),
		.dispatch(dispatch),
		.cond_pass(cond_pass),
		.mfc(mfc),
		.state(state)
	);

	micro_rom #(.last_state(last_state)) micro_rom_inst (
		.clk(clk),
		.arst_n(arst_n),
		.state(state),
		.mw(mw.rom),
		.ctrl(ctrl)
	);

	instr_decoder instr_decoder_inst (.instr(instr), .dispatch(dispatch));

	cond_eval cond_eval_inst (.instr(instr), .flags(flags), .cond_pass(cond_pass));

	// same edge as the ctrl register, so the opcode matches its dp word
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_op_q <= '0;
		end else begin
			alu_op_q <= instr[24:21];
		end
	end

	// --------------------
	// control outputs
	// --------------------
	assign mfa = ctrl[ctrl_mfa];
	assign ir_load = ctrl[ctrl_ir_load];
	assign pc_write = ctrl[ctrl_pc_write];
	assign imm_sel = ctrl[ctrl_imm_sel];
	assign rf_write = ctrl[ctrl_rf_write];
	assign flags_write = ctrl[ctrl_flags_write];
	assign alu_op = ctrl[ctrl_alu_en] ? alu_op_q : '0;     // zero outside dp words

endmodule

// ==== test/control_unit_tb.sv ====
// control unit testbench: clock, reset, lfsr stimulus, reference model, assertions, report
`timescale 1ns/1ps

module control_unit_tb;
	import cu_pkg::*;

	localparam int max_cycles = 200 * 11;   // 200 instructions, worst case 11 cycles each

	logic clk;
	logic arst_n;
	instr_t instr;
	flags_t flags;
	logic mfc;
	logic mfa;
	logic ir_load;
	logic pc_write;
	alu_op_t alu_op;
	logic imm_sel;
	logic rf_write;
	logic flags_write;

	logic [31:0] lfsr_q;
	int err [1:5] = '{default: 0};      // per test
	int hits [1:5];                     // cycles where a check applied
	int cycles = 0;
	logic seen_pc;                      // first pc_write after reset
	logic mem_pending;                  // fetch issued, mfc not yet seen
	logic wait_cyc;
	logic exp_dp;
	logic exp_pass;
	logic exp_cmp;                      // tst teq cmp cmn
	logic dp_hit;
	logic fail_hit;
	logic other_hit;

	control_unit control_unit_inst (
		.clk(clk),
		.arst_n(arst_n),
		.instr(instr),
		.flags(flags),
		.mfc(mfc),
		.mfa(mfa),
		.ir_load(ir_load),
		.pc_write(pc_write),
		.alu_op(alu_op),
		.imm_sel(imm_sel),
		.rf_write(rf_write),
		.flags_write(flags_write)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;      // 100 ns

	// --------------------
	// reference model
	// --------------------
	// arm style: test picked by cond[3:1], odd codes negate it
	function automatic logic cond_holds(input logic [3:0] cond, input flags_t f);
		logic base;
		case (cond[3:1])
			3'd0: base = f[2];                          // eq ne
			3'd1: base = f[1];                          // cs cc
			3'd2: base = f[3];                          // mi pl
			3'd3: base = f[0];                          // vs vc
			3'd4: base = f[1] && !f[2];                 // hi ls
			3'd5: base = (f[3] == f[0]);                // ge lt
			3'd6: base = !f[2] && (f[3] == f[0]);       // gt le
			default: base = 1'b1;                       // al
		endcase
		return (cond == 4'b1111) ? 1'b0 : (base ^ cond[0]);    // nv never
	endfunction

	function automatic logic dp_encoding(input instr_t i);
		if ((i[24:23] == 2'b10) && !i[20]) begin
			return 1'b0;                                // misc space
		end
		return (i[27:25] == 3'b001) || ((i[27:25] == 3'b000) && !i[4]);
	endfunction

	assign exp_dp = dp_encoding(instr);
	assign exp_pass = cond_holds(instr[31:28], flags);
	assign exp_cmp = (instr[24:23] == 2'b10);           // opcodes 8 to 11
	assign wait_cyc = pc_write || mem_pending;
	assign dp_hit = ir_load && exp_dp && exp_pass;
	assign fail_hit = ir_load && exp_dp && !exp_pass;
	assign other_hit = ir_load && !exp_dp;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seen_pc <= 1'b0;
			mem_pending <= 1'b0;
			hits <= '{default: 0};
		end else begin
			seen_pc <= seen_pc || pc_write;
			mem_pending <= wait_cyc && !mfc;            // clears on mfc high
			hits[1] <= hits[1] + int'(!seen_pc);
			hits[2] <= hits[2] + int'(wait_cyc && mfc);
			hits[3] <= hits[3] + int'(dp_hit);
			hits[4] <= hits[4] + int'(fail_hit);
			hits[5] <= hits[5] + int'(other_hit);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not complete within %0d cycles", max_cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function void log_error(input int k, input string line);
		err[k] = err[k] + 1;
		$display("%s", line);
	endfunction

	// --------------------
	// checks
	// --------------------
	a_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!seen_pc && !pc_write |-> {mfa, ir_load, imm_sel, rf_write, flags_write, alu_op} == '0)
		else log_error(1, $sformatf("Error: controls = %h, expected 00",
			$sampled({mfa, ir_load, imm_sel, rf_write, flags_write, alu_op})));

	a_mfa_hold: assert property (@(posedge clk) disable iff (!arst_n) wait_cyc |=> mfa)
		else log_error(2, $sformatf("Error: mfa = %h, expected 1", $sampled(mfa)));
	a_no_early_ir: assert property (@(posedge clk) disable iff (!arst_n) wait_cyc |=> !ir_load)
		else log_error(2, $sformatf("Error: ir_load = %h, expected 0", $sampled(ir_load)));
	a_ir_after_mfc: assert property (@(posedge clk) disable iff (!arst_n)
		$past(wait_cyc && mfc, 2) |-> ir_load)
		else log_error(2, $sformatf("Error: ir_load = %h, expected 1", $sampled(ir_load)));

	a_dp_alu_op: assert property (@(posedge clk) disable iff (!arst_n)
		dp_hit |=> alu_op == instr[24:21])
		else log_error(3, $sformatf("Error: alu_op = %h, expected %h",
			$sampled(alu_op), $sampled(instr[24:21])));
	a_dp_imm_sel: assert property (@(posedge clk) disable iff (!arst_n)
		dp_hit |=> imm_sel == instr[25])
		else log_error(3, $sformatf("Error: imm_sel = %h, expected %h",
			$sampled(imm_sel), $sampled(instr[25])));
	a_dp_rf_write: assert property (@(posedge clk) disable iff (!arst_n)
		dp_hit |=> rf_write == !exp_cmp)
		else log_error(3, $sformatf("Error: rf_write = %h, expected %h",
			$sampled(rf_write), !$sampled(exp_cmp)));
	a_dp_flags_write: assert property (@(posedge clk) disable iff (!arst_n)
		dp_hit |=> flags_write == exp_cmp)
		else log_error(3, $sformatf("Error: flags_write = %h, expected %h",
			$sampled(flags_write), $sampled(exp_cmp)));
	a_dp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		$past(dp_hit, 2) |-> !pc_write && !rf_write && !flags_write)
		else log_error(3, "dp word lasted more than one cycle or pc_write came early");
	a_dp_refetch: assert property (@(posedge clk) disable iff (!arst_n)
		$past(dp_hit, 3) |-> pc_write)
		else log_error(3, "no pc_write two cycles after the dp word");

	a_fail_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		fail_hit |=> !rf_write && !flags_write && !pc_write)
		else log_error(4, "failed condition still wrote a register or flags");
	a_fail_refetch: assert property (@(posedge clk) disable iff (!arst_n)
		$past(fail_hit, 2) |-> pc_write)
		else log_error(4, "failed condition did not refetch one cycle after the quiet cycle");

	a_other_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		other_hit |=> !rf_write && !flags_write && !pc_write)
		else log_error(5, "unsupported encoding wrote a register or flags");
	a_other_refetch: assert property (@(posedge clk) disable iff (!arst_n)
		$past(other_hit, 2) |-> pc_write)
		else log_error(5, "unsupported encoding did not refetch one cycle after the quiet cycle");

	// --------------------
	// stimulus
	// --------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);                     // one step per bit
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic wait_pc_write();
		do begin
			@(posedge clk);
			#1;
		end while (!pc_write);
	endtask

	// force a supported dp encoding, keeping the random opcode
	task automatic force_dp(inout instr_t i);
		i[27:26] = 2'b00;
		i[4] = i[25] ? i[4] : 1'b0;                         // no register shift
		i[20] = (i[24:23] == 2'b10) ? 1'b1 : i[20];         // out of misc space
	endtask

	task automatic make_instr(input int kind, output instr_t i, output flags_t f);
		logic [31:0] r;
		rand_bits(32, r);
		i = r;
		rand_bits(4, r);
		f = r[3:0];
		rand_bits(2, r);
		case (kind)
			3: begin
				force_dp(i);
				i[31:28] = r[0] ? 4'b1110 : i[31:28];       // mostly al
			end
			4: begin
				force_dp(i);
				if (r[0] || (i[31:28] == 4'b1110)) begin
					i[31:28] = 4'b1111;                     // nv
				end
			end
			5: begin
				i[31:28] = 4'b1110;
				case (r[1:0])
					2'd0: i[27:26] = 2'b01;                 // ldr str
					2'd1: i[27] = 1'b1;                     // branch, ldm stm, coproc
					2'd2: begin
						i[27:25] = 3'b000;
						i[4] = 1'b1;                        // register shift
					end
					default: begin
						i[27:26] = 2'b00;
						i[24:23] = 2'b10;
						i[20] = 1'b0;                       // misc
					end
				endcase
			end
			default: ;                                      // fully random
		endcase
	endtask

	// starts in a cycle with pc_write, ends at the next pc_write
	task automatic run_instr(input int kind);
		logic [31:0] r;
		instr_t i;
		flags_t f;
		make_instr(kind, i, f);
		instr = i;
		flags = f;
		rand_bits(3, r);
		repeat (r % 6) begin                                // mfc back-pressure
			@(posedge clk);
			#1;
		end
		mfc = 1'b1;
		@(posedge clk);
		#1;
		mfc = 1'b0;
		wait_pc_write();
	endtask

	task automatic report_test(input int k, input string name);
		@(posedge clk);                                     // last refetch check
		#1;
		if (hits[k] == 0) begin
			log_error(k, $sformatf("test %0d %s never reached its checks", k, name));
		end
		$display("test %0d %s: %0d checks reached, %0d errors", k, name, hits[k], err[k]);
	endtask

	initial begin
		int failed;
		arst_n = 1'b0;
		instr = '0;
		flags = '0;
		mfc = 1'b0;
		lfsr_q = 32'h3dc9;
		failed = 0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		wait_pc_write();
		report_test(1, "reset");
		repeat (40) run_instr(2);
		report_test(2, "handshake");
		repeat (60) run_instr(3);
		report_test(3, "dp_pass");
		repeat (50) run_instr(4);
		report_test(4, "cond_fail");
		repeat (50) run_instr(5);
		report_test(5, "non_dp");
		foreach (err[k]) begin
			failed = failed + int'(err[k] != 0);
		end
		$display("summary: 5 tests, %0d failed, %0d errors", failed, err.sum());
		if (failed == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
verilog/cu_pkg.sv
verilog/microword_if.sv
verilog/cond_eval.sv
verilog/instr_decoder.sv
verilog/micro_rom.sv
verilog/microsequencer.sv
verilog/control_unit.sv
test/control_unit_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -f project.f --top-module control_unit_tb -Mdir obj_dir -o control_unit_tb
	./obj_dir/control_unit_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
